// File: hw/rv_isa_pkg.sv
/*
 * rv32 isa definitions for the decode/issue stage
 * match patterns, micro-ops and immediate formats
 */

package rv_isa_pkg;

  // ----------------------------
  // instruction match patterns
  // ----------------------------
  // ? bits are don't-care for casez matching
  // r-type
  localparam logic [31:0] RVI_INST_ADD  = 32'b0000000_?????_?????_000_?????_0110011;
  localparam logic [31:0] RVI_INST_MUL  = 32'b0000001_?????_?????_000_?????_0110011;
  // i-type
  localparam logic [31:0] RVI_INST_ADDI = 32'b???????_?????_?????_000_?????_0010011;
  localparam logic [31:0] RVI_INST_LW   = 32'b???????_?????_?????_010_?????_0000011;
  localparam logic [31:0] RVI_INST_JALR = 32'b???????_?????_?????_000_?????_1100111;
  // s-type, b-type
  localparam logic [31:0] RVI_INST_SW   = 32'b???????_?????_?????_010_?????_0100011;
  localparam logic [31:0] RVI_INST_BNE  = 32'b???????_?????_?????_001_?????_1100011;
  // j-type
  localparam logic [31:0] RVI_INST_JAL  = 32'b???????_?????_?????_???_?????_1101111;

  // ----------------------------
  // micro-ops
  // ----------------------------
  // addi folds into OP_ADD, op2_sel tells them apart
  typedef enum logic [2:0] {
    OP_ADD,
    OP_MUL,
    OP_LW,
    OP_SW,
    OP_JAL,
    OP_JALR,
    OP_BNE
  } rv_uop;

  // immediate formats handled by imm_gen
  typedef enum logic [1:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_J
  } rv_imm_type;

endpackage

// File: hw/uarch_pkg.sv
/*
 * microarchitecture definitions for the decode/issue stage
 */

package uarch_pkg;

  // architectural register count, x0 included
  localparam int NUM_REGS   = 32;
  localparam int REG_ADDR_W = 5;

  // jump kind carried to execute
  typedef enum logic [1:0] {
    J_NONE,
    J_JAL,
    J_JALR
  } jump_kind;

  // second alu operand source
  typedef enum logic {
    OP2_RF,
    OP2_IMM
  } op2_src;

  // memory access vs branch compare
  typedef enum logic {
    OP3_MEM,
    OP3_BR
  } op3_src;

endpackage

// File: hw/inst_decoder.sv
/*
 * instruction decoder
 * table-driven mapping of an rv32 word to micro-op, register
 * addresses and operand selects
 */

`timescale 1ns/1ns

module inst_decoder import rv_isa_pkg::*, uarch_pkg::*; (
  input  logic [31:0] inst,

  output logic        val,
  output rv_uop       uop,
  output jump_kind    jump,
  output logic [4:0]  raddr0,
  output logic [4:0]  raddr1,
  output logic [4:0]  waddr,
  output logic        wen,
  output rv_imm_type  imm_sel,
  output op2_src      op2_sel,
  output op3_src      op3_sel
);

  // ----------------------------
  // register fields
  // ----------------------------
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rd;

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  // one table row, drives every control output
  task automatic cs(
    input logic       c_val,
    input rv_uop      c_uop,
    input jump_kind   c_jump,
    input logic [4:0] c_raddr0,
    input logic [4:0] c_raddr1,
    input logic [4:0] c_waddr,
    input logic       c_wen,
    input rv_imm_type c_imm_sel,
    input op2_src     c_op2_sel,
    input op3_src     c_op3_sel
  );
    val     = c_val;
    uop     = c_uop;
    jump    = c_jump;
    raddr0  = c_raddr0;
    raddr1  = c_raddr1;
    waddr   = c_waddr;
    wen     = c_wen;
    imm_sel = c_imm_sel;
    op2_sel = c_op2_sel;
    op3_sel = c_op3_sel;
  endtask

  // ----------------------------
  // control signal table
  // ----------------------------
  // unused source -> address 0, never stalls
  // don't-care selects pinned to IMM_I / OP3_MEM
  // bne marks rd written, kept from the older core
  always_comb begin
    casez (inst)
      //              val   uop      jump    rs0   rs1   rd    wen   imm    op2      op3
      RVI_INST_ADD:  cs(1'b1, OP_ADD,  J_NONE, rs1,  rs2,  rd,   1'b1, IMM_I, OP2_RF,  OP3_MEM);
      RVI_INST_ADDI: cs(1'b1, OP_ADD,  J_NONE, rs1,  5'd0, rd,   1'b1, IMM_I, OP2_IMM, OP3_MEM);
      RVI_INST_MUL:  cs(1'b1, OP_MUL,  J_NONE, rs1,  rs2,  rd,   1'b1, IMM_I, OP2_RF,  OP3_MEM);
      RVI_INST_LW:   cs(1'b1, OP_LW,   J_NONE, rs1,  5'd0, rd,   1'b1, IMM_I, OP2_IMM, OP3_MEM);
      RVI_INST_SW:   cs(1'b1, OP_SW,   J_NONE, rs1,  rs2,  5'd0, 1'b0, IMM_S, OP2_IMM, OP3_MEM);
      RVI_INST_JAL:  cs(1'b1, OP_JAL,  J_JAL,  5'd0, 5'd0, rd,   1'b1, IMM_J, OP2_IMM, OP3_MEM);
      RVI_INST_JALR: cs(1'b1, OP_JALR, J_JALR, rs1,  5'd0, rd,   1'b1, IMM_I, OP2_IMM, OP3_MEM);
      RVI_INST_BNE:  cs(1'b1, OP_BNE,  J_NONE, rs1,  rs2,  rd,   1'b1, IMM_B, OP2_RF,  OP3_BR);
      // unknown word, no hazard and no write
      default:       cs(1'b0, OP_ADD,  J_NONE, 5'd0, 5'd0, 5'd0, 1'b0, IMM_I, OP2_RF,  OP3_MEM);
    endcase
  end

endmodule

// File: hw/imm_gen.sv
/*
 * immediate generator
 * sign-extended i, s, b and j immediates
 */

`timescale 1ns/1ns

module imm_gen import rv_isa_pkg::*; (
  input  logic [31:0] inst,
  input  rv_imm_type  imm_sel,
  output logic [31:0] imm
);

  // sign bit is always inst[31]
  always_comb begin
    case (imm_sel)
      IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
      // split field, high part in funct7 slot
      IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      // halfword offset, bit 0 implied zero
      IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
      // 21-bit jump offset
      IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

// File: hw/reg_file.sv
/*
 * integer register file
 * two combinational reads, one synchronous write, x0 never written
 */

`timescale 1ns/1ns

module reg_file import uarch_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] raddr0,
  input  logic [REG_ADDR_W-1:0] raddr1,
  input  logic                  wen,
  input  logic [REG_ADDR_W-1:0] waddr,
  input  logic [31:0]           wdata,
  output logic [31:0]           rdata0,
  output logic [31:0]           rdata1
);

  logic [31:0] regs [NUM_REGS];

  // writes to x0 dropped, entry stays at its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // read ports, no write-through
  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

  // x0 holds zero across every writeback after reset
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    ((raddr0 == '0) |-> (rdata0 == '0)) and ((raddr1 == '0) |-> (rdata1 == '0)));

endmodule

// File: hw/issue_ctrl.sv
/*
 * issue control
 * input/output handshakes, pending-register scoreboard,
 * single issue register and illegal-word pulse
 */

`timescale 1ns/1ns

module issue_ctrl import rv_isa_pkg::*, uarch_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic                  issue_ready,
  input  logic                  dec_val,
  input  rv_uop                 dec_uop,
  input  jump_kind              dec_jump,
  input  logic [REG_ADDR_W-1:0] dec_raddr0,
  input  logic [REG_ADDR_W-1:0] dec_raddr1,
  input  logic [REG_ADDR_W-1:0] dec_waddr,
  input  logic                  dec_wen,
  input  op2_src                dec_op2_sel,
  input  op3_src                dec_op3_sel,
  input  logic [31:0]           imm,
  input  logic [31:0]           rdata0,
  input  logic [31:0]           rdata1,
  input  logic [31:0]           in_pc,
  input  logic                  wb_en,
  input  logic [REG_ADDR_W-1:0] wb_addr,
  output logic                  in_ready,
  output logic                  issue_valid,
  output rv_uop                 issue_uop,
  output jump_kind              issue_jump,
  output op2_src                issue_op2_sel,
  output op3_src                issue_op3_sel,
  output logic [31:0]           issue_rs1_val,
  output logic [31:0]           issue_rs2_val,
  output logic [31:0]           issue_imm,
  output logic [31:0]           issue_pc,
  output logic [REG_ADDR_W-1:0] issue_waddr,
  output logic                  issue_wen,
  output logic                  illegal
);

  logic [NUM_REGS-1:0] pending;
  logic                slot_free;
  logic                hazard;
  logic                accept;
  logic                sets_dest;

  // ----------------------------
  // stall logic
  // ----------------------------
  // register slot empty or draining this cycle
  assign slot_free = !issue_valid || issue_ready;

  // raw on either source, waw on dest; address 0 never pending
  assign hazard = ((dec_raddr0 != '0) && pending[dec_raddr0])
               || ((dec_raddr1 != '0) && pending[dec_raddr1])
               || (dec_wen && (dec_waddr != '0) && pending[dec_waddr]);

  assign in_ready  = slot_free && !hazard;
  assign accept    = in_valid && in_ready;
  assign sets_dest = accept && dec_val && dec_wen && (dec_waddr != '0);

  // scoreboard, writeback clears, new dest sets
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wb_en) pending[wb_addr] <= 1'b0;
      if (sets_dest) pending[dec_waddr] <= 1'b1;
    end
  end

  // ----------------------------
  // issue register
  // ----------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_valid <= 1'b0;
      illegal     <= 1'b0;
    end else begin
      // illegal word consumed, one-cycle pulse
      illegal <= accept && !dec_val;
      if (accept && dec_val) issue_valid <= 1'b1;
      else if (issue_ready) issue_valid <= 1'b0;
    end
  end

  // payload only moves on legal acceptance
  always_ff @(posedge clk) begin
    if (accept && dec_val) begin
      issue_uop     <= dec_uop;
      issue_jump    <= dec_jump;
      issue_op2_sel <= dec_op2_sel;
      issue_op3_sel <= dec_op3_sel;
      issue_rs1_val <= rdata0;
      issue_rs2_val <= rdata1;
      issue_imm     <= imm;
      issue_pc      <= in_pc;
      issue_waddr   <= dec_waddr;
      issue_wen     <= dec_wen;
    end
  end

  // stalled bundle held until execute takes it
  a_issue_hold: assert property (@(posedge clk) disable iff (rst)
    (issue_valid && !issue_ready) |=> issue_valid && $stable(issue_uop)
      && $stable(issue_jump) && $stable(issue_op2_sel) && $stable(issue_op3_sel)
      && $stable(issue_rs1_val) && $stable(issue_rs2_val) && $stable(issue_imm)
      && $stable(issue_pc) && $stable(issue_waddr) && $stable(issue_wen));

  // x0 never tracked as pending
  a_x0_not_pending: assert property (@(posedge clk) disable iff (rst) !pending[0]);

endmodule

// File: hw/decode_issue.sv
/*
 * decode and issue stage top
 * decoder, immediate generator, register file and issue control
 */

`timescale 1ns/1ns

module decode_issue import rv_isa_pkg::*, uarch_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic [31:0]           in_inst,
  input  logic [31:0]           in_pc,
  input  logic                  issue_ready,
  input  logic                  wb_en,
  input  logic [REG_ADDR_W-1:0] wb_addr,
  input  logic [31:0]           wb_data,
  output logic                  in_ready,
  output logic                  issue_valid,
  output rv_uop                 issue_uop,
  output jump_kind              issue_jump,
  output op2_src                issue_op2_sel,
  output op3_src                issue_op3_sel,
  output logic [31:0]           issue_rs1_val,
  output logic [31:0]           issue_rs2_val,
  output logic [31:0]           issue_imm,
  output logic [31:0]           issue_pc,
  output logic [REG_ADDR_W-1:0] issue_waddr,
  output logic                  issue_wen,
  output logic                  illegal
);

  // ----------------------------
  // decode outputs
  // ----------------------------
  logic                  dec_val;
  rv_uop                 dec_uop;
  jump_kind              dec_jump;
  logic [REG_ADDR_W-1:0] dec_raddr0;
  logic [REG_ADDR_W-1:0] dec_raddr1;
  logic [REG_ADDR_W-1:0] dec_waddr;
  logic                  dec_wen;
  rv_imm_type            dec_imm_sel;
  op2_src                dec_op2_sel;
  op3_src                dec_op3_sel;
  logic [31:0]           imm;
  logic [31:0]           rdata0;
  logic [31:0]           rdata1;

  inst_decoder inst_decoder_inst (
    .inst    (in_inst),
    .val     (dec_val),
    .uop     (dec_uop),
    .jump    (dec_jump),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .imm_sel (dec_imm_sel),
    .op2_sel (dec_op2_sel),
    .op3_sel (dec_op3_sel)
  );

  imm_gen imm_gen_inst (
    .inst    (in_inst),
    .imm_sel (dec_imm_sel),
    .imm     (imm)
  );

  // writeback lands here and clears the scoreboard below
  reg_file reg_file_inst (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (dec_raddr0),
    .raddr1 (dec_raddr1),
    .wen    (wb_en),
    .waddr  (wb_addr),
    .wdata  (wb_data),
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

  issue_ctrl issue_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .issue_ready   (issue_ready),
    .dec_val       (dec_val),
    .dec_uop       (dec_uop),
    .dec_jump      (dec_jump),
    .dec_raddr0    (dec_raddr0),
    .dec_raddr1    (dec_raddr1),
    .dec_waddr     (dec_waddr),
    .dec_wen       (dec_wen),
    .dec_op2_sel   (dec_op2_sel),
    .dec_op3_sel   (dec_op3_sel),
    .imm           (imm),
    .rdata0        (rdata0),
    .rdata1        (rdata1),
    .in_pc         (in_pc),
    .wb_en         (wb_en),
    .wb_addr       (wb_addr),
    .in_ready      (in_ready),
    .issue_valid   (issue_valid),
    .issue_uop     (issue_uop),
    .issue_jump    (issue_jump),
    .issue_op2_sel (issue_op2_sel),
    .issue_op3_sel (issue_op3_sel),
    .issue_rs1_val (issue_rs1_val),
    .issue_rs2_val (issue_rs2_val),
    .issue_imm     (issue_imm),
    .issue_pc      (issue_pc),
    .issue_waddr   (issue_waddr),
    .issue_wen     (issue_wen),
    .illegal       (illegal)
  );

endmodule

// File: tests/issue_checker.sv
/*
 * issue port checker
 * compares issue handshakes with the expected queue, watches stalls
 */

`timescale 1ns/1ns

module issue_checker import rv_isa_pkg::*, uarch_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        in_ready,
  input logic        issue_valid,
  input logic        issue_ready,
  input rv_uop       issue_uop,
  input jump_kind    issue_jump,
  input op2_src      issue_op2_sel,
  input op3_src      issue_op3_sel,
  input logic [31:0] issue_rs1_val,
  input logic [31:0] issue_rs2_val,
  input logic [31:0] issue_imm,
  input logic [31:0] issue_pc,
  input logic [4:0]  issue_waddr,
  input logic        issue_wen,
  input logic        illegal
);

  // bundle layout, lsb first: wen, waddr, pc, imm[69:38], rs2, rs1, op3, op2, jump, uop
  logic [140:0] exp_q[$];
  logic         chk_q[$];
  logic [140:0] want;
  logic [140:0] got;
  logic [140:0] cur;
  logic [140:0] held_bundle;
  logic         held = 1'b0;
  logic         chk;
  int           pass_count = 0;
  int           err_count = 0;
  int           illegal_seen = 0;

  function automatic logic [140:0] pack_bundle(
    input logic [2:0] uop, input logic [1:0] jump, input logic op2, input logic op3,
    input logic [31:0] rs1v, input logic [31:0] rs2v, input logic [31:0] imm,
    input logic [31:0] pc, input logic [4:0] wa, input logic wen);
    return {uop, jump, op2, op3, rs1v, rs2v, imm, pc, wa, wen};
  endfunction

  task automatic expect_bundle(
    input logic [2:0] uop, input logic [1:0] jump, input logic op2, input logic op3,
    input logic [31:0] rs1v, input logic [31:0] rs2v, input logic [31:0] imm,
    input logic imm_chk, input logic [31:0] pc, input logic [4:0] wa, input logic wen);
    exp_q.push_back(pack_bundle(uop, jump, op2, op3, rs1v, rs2v, imm, pc, wa, wen));
    chk_q.push_back(imm_chk);
  endtask

  task automatic flag_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    err_count++;
  endtask

  function automatic int outstanding();
    return exp_q.size();
  endfunction

  // sampled mid-cycle, all inputs settled
  always @(negedge clk) begin
    if (!rst) begin
      cur = pack_bundle(issue_uop, issue_jump, issue_op2_sel, issue_op3_sel, issue_rs1_val,
                        issue_rs2_val, issue_imm, issue_pc, issue_waddr, issue_wen);
      if (illegal) begin
        illegal_seen++;
        $display("test illegal word: pulse seen at %0t ns", $time);
      end
      // stalled bundle must not move
      if (held && issue_valid && (cur !== held_bundle))
        flag_error($sformatf("issue outputs changed while stalled, pc %h", issue_pc));
      if (held && !issue_valid)
        flag_error("issue_valid dropped while stalled");
      if (issue_valid && !issue_ready && in_ready)
        flag_error("in_ready high while the issue register is stalled");
      if (issue_valid && issue_ready) begin
        if (exp_q.size() == 0) begin
          flag_error($sformatf("unexpected issue handshake, pc %h", issue_pc));
        end else begin
          want = exp_q.pop_front();
          chk = chk_q.pop_front();
          // r-type imm is not defined by the isa
          got = pack_bundle(issue_uop, issue_jump, issue_op2_sel, issue_op3_sel,
                            issue_rs1_val, issue_rs2_val, chk ? issue_imm : want[69:38],
                            issue_pc, issue_waddr, issue_wen);
          if (got !== want) begin
            flag_error($sformatf("pc %h bundle got %h want %h", issue_pc, got, want));
          end else begin
            pass_count++;
            $display("test pc %h: issued ok", issue_pc);
          end
        end
      end
      held = issue_valid && !issue_ready;
      held_bundle = cur;
    end
  end

endmodule

// File: tests/decode_issue_tb.sv
/*
 * decode/issue stage testbench
 * table-driven stimulus, writeback driver with random delays, watchdog
 */

`timescale 1ns/1ns

module decode_issue_tb import rv_isa_pkg::*, uarch_pkg::*;;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  typedef struct {
    logic [31:0] inst;
    rv_uop       uop;
    jump_kind    jump;
    op2_src      op2;
    op3_src      op3;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  wa;
    logic        wen;
    logic [31:0] imm;
    logic        imm_chk;
    logic        legal;
  } row_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        in_valid;
  logic [31:0] in_inst;
  logic [31:0] in_pc;
  logic        issue_ready;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        in_ready;
  logic        issue_valid;
  rv_uop       issue_uop;
  jump_kind    issue_jump;
  op2_src      issue_op2_sel;
  op3_src      issue_op3_sel;
  logic [31:0] issue_rs1_val;
  logic [31:0] issue_rs2_val;
  logic [31:0] issue_imm;
  logic [31:0] issue_pc;
  logic [4:0]  issue_waddr;
  logic        issue_wen;
  logic        illegal;

  row_t        rows[$];
  // register model built from driven writebacks
  // busy marks a writeback not yet driven
  logic [31:0] model[32];
  logic        busy[32];
  int          idx_q[$];
  logic [36:0] wb_q[$];
  int          illegal_expected = 0;
  integer      seed;

  decode_issue decode_issue_inst (.*);

  issue_checker issue_checker (.*);

  // ------------------------------
  // field encoders
  // ------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  // bne encoding drops bit 0 of the offset
  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic add_row(input logic [31:0] inst, input rv_uop uop, input jump_kind jump,
                         input op2_src op2, input op3_src op3, input logic [4:0] ra,
                         input logic [4:0] rb, input logic [4:0] wa, input logic wen,
                         input logic [31:0] imm, input logic imm_chk, input logic legal);
    rows.push_back('{inst, uop, jump, op2, op3, ra, rb, wa, wen, imm, imm_chk, legal});
  endtask

  task automatic build_table();
    // inst                                  uop jump op2 op3 ra rb wa wen imm chk legal
    add_row(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OPIMM), OP_ADD, J_NONE, OP2_IMM, OP3_MEM,
            5'd0, 5'd0, 5'd1, 1'b1, 32'd5, 1'b1, 1'b1);
    add_row(enc_i(12'hFFD, 5'd0, 3'b000, 5'd2, OPC_OPIMM), OP_ADD, J_NONE, OP2_IMM, OP3_MEM,
            5'd0, 5'd0, 5'd2, 1'b1, 32'hFFFF_FFFD, 1'b1, 1'b1);
    // raw on x1 and x2
    add_row(enc_r(7'd0, 5'd2, 5'd1, 5'd3), OP_ADD, J_NONE, OP2_RF, OP3_MEM,
            5'd1, 5'd2, 5'd3, 1'b1, 32'd0, 1'b0, 1'b1);
    add_row(enc_r(7'd1, 5'd1, 5'd3, 5'd4), OP_MUL, J_NONE, OP2_RF, OP3_MEM,
            5'd3, 5'd1, 5'd4, 1'b1, 32'd0, 1'b0, 1'b1);
    add_row(32'hFFFF_FFFF, OP_ADD, J_NONE, OP2_RF, OP3_MEM,
            5'd0, 5'd0, 5'd0, 1'b0, 32'd0, 1'b0, 1'b0);
    add_row(enc_i(12'hFF8, 5'd3, 3'b010, 5'd5, OPC_LOAD), OP_LW, J_NONE, OP2_IMM, OP3_MEM,
            5'd3, 5'd0, 5'd5, 1'b1, 32'hFFFF_FFF8, 1'b1, 1'b1);
    add_row(enc_s(12'd12, 5'd4, 5'd5), OP_SW, J_NONE, OP2_IMM, OP3_MEM,
            5'd5, 5'd4, 5'd0, 1'b0, 32'd12, 1'b1, 1'b1);
    // rd field of -16 holds {imm[4:1], imm[11]} = x17
    add_row(enc_b(13'h1FF0, 5'd2, 5'd1), OP_BNE, J_NONE, OP2_RF, OP3_BR,
            5'd1, 5'd2, 5'd17, 1'b1, 32'hFFFF_FFF0, 1'b1, 1'b1);
    add_row(enc_j(21'h800, 5'd1), OP_JAL, J_JAL, OP2_IMM, OP3_MEM,
            5'd0, 5'd0, 5'd1, 1'b1, 32'h800, 1'b1, 1'b1);
    add_row(enc_i(12'hFFC, 5'd1, 3'b000, 5'd6, OPC_JALR), OP_JALR, J_JALR, OP2_IMM, OP3_MEM,
            5'd1, 5'd0, 5'd6, 1'b1, 32'hFFFF_FFFC, 1'b1, 1'b1);
    add_row(enc_r(7'd0, 5'd6, 5'd0, 5'd7), OP_ADD, J_NONE, OP2_RF, OP3_MEM,
            5'd0, 5'd6, 5'd7, 1'b1, 32'd0, 1'b0, 1'b1);
    add_row(enc_j(21'h10_0000, 5'd0), OP_JAL, J_JAL, OP2_IMM, OP3_MEM,
            5'd0, 5'd0, 5'd0, 1'b1, 32'hFFF0_0000, 1'b1, 1'b1);
    add_row(enc_i(12'd1, 5'd17, 3'b000, 5'd8, OPC_OPIMM), OP_ADD, J_NONE, OP2_IMM, OP3_MEM,
            5'd17, 5'd0, 5'd8, 1'b1, 32'd1, 1'b1, 1'b1);
  endtask

  // hold one row until taken
  // expected bundle built at acceptance
  task automatic apply_row(input int i);
    row_t r;
    logic accepted;
    r = rows[i];
    accepted = 1'b0;
    in_valid = 1'b1;
    in_inst = r.inst;
    in_pc = 32'h100 + 4 * i;
    while (!accepted) begin
      @(negedge clk);
      if (in_ready) begin
        if (((r.ra != 0) && busy[r.ra]) || ((r.rb != 0) && busy[r.rb])
            || (r.wen && (r.wa != 0) && busy[r.wa]))
          issue_checker.flag_error($sformatf("row %0d accepted over a pending register", i));
        if (r.legal) begin
          issue_checker.expect_bundle(r.uop, r.jump, r.op2, r.op3, model[r.ra], model[r.rb],
                                      r.imm, r.imm_chk, in_pc, r.wa, r.wen);
          idx_q.push_back(i);
          if (r.wen && (r.wa != 0)) busy[r.wa] = 1'b1;
        end else begin
          illegal_expected++;
        end
        accepted = 1'b1;
      end
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  initial begin
    forever #10 clk = ~clk;
  end

  // queue a writeback for every issued row with wen
  always @(negedge clk) begin
    if (!rst && issue_valid && issue_ready && (idx_q.size() > 0)) begin
      int idx;
      idx = idx_q.pop_front();
      if (rows[idx].wen)
        wb_q.push_back({rows[idx].wa, 32'hA000_0000 + 32'(idx) * 32'h0001_0101});
    end
  end

  // writeback driver and issue_ready toggling share one random source
  initial begin
    int wb_wait;
    logic [36:0] e;
    seed = 32'h1279;
    wb_wait = 0;
    forever begin
      @(posedge clk);
      #2;
      wb_en = 1'b0;
      issue_ready = (({$random(seed)} % 4) != 0);
      if (wb_q.size() > 0) begin
        if (wb_wait == 0) begin
          e = wb_q.pop_front();
          wb_en = 1'b1;
          wb_addr = e[36:32];
          wb_data = e[31:0];
          if (e[36:32] != 0) model[e[36:32]] = e[31:0];
          busy[e[36:32]] = 1'b0;
          wb_wait = {$random(seed)} % 4;
        end else begin
          wb_wait--;
        end
      end
    end
  end

  // watchdog allows 20 cycles per row
  initial begin
    #1;
    #(rows.size() * 20 * 20);
    $display("timeout: the run did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    in_inst = 32'd0;
    in_pc = 32'd0;
    issue_ready = 1'b0;
    wb_en = 1'b0;
    wb_addr = 5'd0;
    wb_data = 32'd0;
    for (int k = 0; k < 32; k++) begin
      model[k] = 32'd0;
      busy[k] = 1'b0;
    end
    build_table();
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < rows.size(); i++) apply_row(i);
    // drain issue queue and writebacks
    while ((issue_checker.outstanding() != 0) || (wb_q.size() != 0)) @(negedge clk);
    repeat (3) @(negedge clk);
    if (issue_checker.illegal_seen != illegal_expected)
      issue_checker.flag_error($sformatf("illegal pulses %0d, expected %0d",
                               issue_checker.illegal_seen, illegal_expected));
    $display("done: %0d issued ok, %0d illegal, %0d errors", issue_checker.pass_count,
             issue_checker.illegal_seen, issue_checker.err_count);
    if (issue_checker.err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: build.f
hw/rv_isa_pkg.sv
hw/uarch_pkg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/issue_ctrl.sv
hw/decode_issue.sv
tests/issue_checker.sv
tests/decode_issue_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the decode/issue testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module decode_issue_tb -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q -x '\*\* PASS \*\*' &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }
